//--- logic/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ------------------------------
// core dimensions
// ------------------------------
`define CORE_DATA_W      16
`define CORE_NUM_REGS    8

// queue depth is also the number of credits the fetch source starts with.
`define CORE_QUEUE_DEPTH 4
`define CORE_OUT_CREDITS 2

`endif

//--- logic/corePkg.sv
`include "core_settings.svh"

package corePkg;

   // ------------------------------
   // instruction opcodes, bits 15 to 12
   // ------------------------------
   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_OR   = 4'd4,
      OP_XOR  = 4'd5,
      OP_ADDI = 4'd6,
      OP_LDI  = 4'd7
   } opcodeE;

   // ------------------------------
   // ALU operations
   // ------------------------------
   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_AND   = 3'd2,
      ALU_OR    = 3'd3,
      ALU_XOR   = 3'd4,
      ALU_PASSB = 3'd5   // operand B straight through, used by LDI.
   } aluOpE;

   typedef logic [$clog2(`CORE_NUM_REGS)-1:0] regIdxT;

endpackage

//--- logic/instrDecoder.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module instrDecoder (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    instrValid,
   input  logic [`CORE_DATA_W-1:0] instr,
   input  logic                    exAdvance,
   output logic                    creditReturn,
   output logic                    decValid,
   output corePkg::aluOpE          decAluOp,
   output corePkg::regIdxT         decRd,
   output corePkg::regIdxT         rs1Idx,
   output corePkg::regIdxT         rs2Idx,
   output logic                    decWrites,
   output logic                    decUseImm,
   output logic [`CORE_DATA_W-1:0] decImm
);
   import corePkg::*;

   localparam int PTR_W = $clog2(`CORE_QUEUE_DEPTH);

   logic [`CORE_DATA_W-1:0] queue [`CORE_QUEUE_DEPTH];
   logic [PTR_W-1:0]        wrPtr;
   logic [PTR_W-1:0]        rdPtr;
   logic [PTR_W:0]          count;
   logic                    pop;
   logic [`CORE_DATA_W-1:0] head;
   opcodeE                  opcode;

   // ------------------------------
   // instruction queue
   // ------------------------------
   assign decValid     = (count != '0);
   assign pop          = decValid && exAdvance;
   assign creditReturn = pop;                     // one credit back per instruction leaving.

   always_ff @(posedge CLK) begin
      if (instrValid) begin
         queue[wrPtr] <= instr;                   // sender only pushes while it holds a credit.
      end
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (instrValid) begin
            wrPtr <= (wrPtr == PTR_W'(`CORE_QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= (rdPtr == PTR_W'(`CORE_QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         end
         case ({instrValid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ------------------------------
   // decode of the head entry
   // ------------------------------
   assign head   = queue[rdPtr];
   assign opcode = opcodeE'(head[15:12]);
   assign decRd  = head[11:9];
   assign rs1Idx = head[8:6];
   assign rs2Idx = head[5:3];
   assign decImm = {{(`CORE_DATA_W - 6){head[5]}}, head[5:0]};

   always_comb begin
      decAluOp  = ALU_ADD;
      decWrites = 1'b1;
      decUseImm = 1'b0;
      case (opcode)
         OP_ADD:  decAluOp = ALU_ADD;
         OP_SUB:  decAluOp = ALU_SUB;
         OP_AND:  decAluOp = ALU_AND;
         OP_OR:   decAluOp = ALU_OR;
         OP_XOR:  decAluOp = ALU_XOR;
         OP_ADDI: decUseImm = 1'b1;                // rs1 plus the immediate.
         OP_LDI: begin
            decAluOp  = ALU_PASSB;
            decUseImm = 1'b1;
         end
         default: decWrites = 1'b0;               // NOP and unused codes write nothing.
      endcase
   end

endmodule

//--- logic/regFile.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module regFile (
   input  logic                    CLK,
   input  logic                    rst,
   input  corePkg::regIdxT         rs1Idx,
   input  corePkg::regIdxT         rs2Idx,
   output logic [`CORE_DATA_W-1:0] rdData1,
   output logic [`CORE_DATA_W-1:0] rdData2,
   input  logic                    wrEn,
   input  corePkg::regIdxT         wrIdx,
   input  logic [`CORE_DATA_W-1:0] wrData
);

   logic [`CORE_DATA_W-1:0] regs [`CORE_NUM_REGS];

   // ------------------------------
   // write port
   // ------------------------------
   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   // ------------------------------
   // read ports
   // ------------------------------
   // a write at the same edge is not seen here, the execute stage forwards it.
   assign rdData1 = regs[rs1Idx];
   assign rdData2 = regs[rs2Idx];

endmodule

//--- logic/decodeStageReg.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module decodeStageReg (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    exAdvance,
   input  logic                    decValid,
   input  corePkg::aluOpE          decAluOp,
   input  corePkg::regIdxT         decRd,
   input  logic                    decWrites,
   input  logic                    decUseImm,
   input  logic [`CORE_DATA_W-1:0] decImm,
   input  corePkg::regIdxT         rs1Idx,
   input  corePkg::regIdxT         rs2Idx,
   input  logic [`CORE_DATA_W-1:0] rdData1,
   input  logic [`CORE_DATA_W-1:0] rdData2,
   output logic                    exValid,
   output corePkg::aluOpE          exAluOp,
   output corePkg::regIdxT         exRd,
   output corePkg::regIdxT         exRs1,
   output corePkg::regIdxT         exRs2,
   output logic                    exWrites,
   output logic                    exUseImm,
   output logic [`CORE_DATA_W-1:0] exImm,
   output logic [`CORE_DATA_W-1:0] exOpA,
   output logic [`CORE_DATA_W-1:0] exOpB
);

   // ------------------------------
   // valid bit
   // ------------------------------
   always_ff @(posedge CLK) begin
      if (rst) begin
         exValid <= 1'b0;
      end else if (exAdvance) begin
         exValid <= decValid;                     // an empty queue leaves a bubble.
      end
   end

   // ------------------------------
   // decoded fields and operands
   // ------------------------------
   always_ff @(posedge CLK) begin
      if (exAdvance) begin
         exAluOp  <= decAluOp;
         exRd     <= decRd;
         exRs1    <= rs1Idx;                      // indices kept for the forwarding compare.
         exRs2    <= rs2Idx;
         exWrites <= decWrites;
         exUseImm <= decUseImm;
         exImm    <= decImm;
         exOpA    <= rdData1;
         exOpB    <= rdData2;
      end
   end

endmodule

//--- logic/executeUnit.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module executeUnit (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    exValid,
   input  corePkg::aluOpE          exAluOp,
   input  corePkg::regIdxT         exRd,
   input  corePkg::regIdxT         exRs1,
   input  corePkg::regIdxT         exRs2,
   input  logic                    exWrites,
   input  logic                    exUseImm,
   input  logic [`CORE_DATA_W-1:0] exImm,
   input  logic [`CORE_DATA_W-1:0] exOpA,
   input  logic [`CORE_DATA_W-1:0] exOpB,
   input  logic                    resultCredit,
   output logic                    exAdvance,
   output logic                    wrEn,
   output corePkg::regIdxT         wrIdx,
   output logic [`CORE_DATA_W-1:0] wrData,
   output logic                    resultValid,
   output corePkg::regIdxT         resultReg,
   output logic [`CORE_DATA_W-1:0] resultData
);
   import corePkg::*;

   localparam int CRED_W = $clog2(`CORE_OUT_CREDITS + 1);

   logic [CRED_W-1:0]       credits;
   logic                    haveCredit;
   logic                    fwdValid;
   logic [`CORE_DATA_W-1:0] srcA;
   logic [`CORE_DATA_W-1:0] srcB;
   logic [`CORE_DATA_W-1:0] aluB;
   logic [`CORE_DATA_W-1:0] aluOut;

   // ------------------------------
   // forwarding and ALU
   // ------------------------------
   // fwdValid marks a write at the same edge that loaded the stage.
   assign srcA = (fwdValid && exRs1 == resultReg) ? resultData : exOpA;
   assign srcB = (fwdValid && exRs2 == resultReg) ? resultData : exOpB;
   assign aluB = exUseImm ? exImm : srcB;

   always_comb begin
      case (exAluOp)
         ALU_ADD:   aluOut = srcA + aluB;
         ALU_SUB:   aluOut = srcA - aluB;
         ALU_AND:   aluOut = srcA & aluB;
         ALU_OR:    aluOut = srcA | aluB;
         ALU_XOR:   aluOut = srcA ^ aluB;
         ALU_PASSB: aluOut = aluB;
         default:   aluOut = '0;
      endcase
   end

   // ------------------------------
   // issue and output credits
   // ------------------------------
   assign haveCredit = (credits != '0);
   assign wrEn       = exValid && exWrites && haveCredit;
   assign exAdvance  = !exValid || !exWrites || haveCredit;   // NOPs pass without a credit.
   assign wrIdx      = exRd;
   assign wrData     = aluOut;

   always_ff @(posedge CLK) begin
      if (rst) begin
         credits     <= CRED_W'(`CORE_OUT_CREDITS);
         resultValid <= 1'b0;
         fwdValid    <= 1'b0;
      end else begin
         resultValid <= wrEn;
         if (exAdvance) begin
            fwdValid <= wrEn;
         end
         case ({wrEn, resultCredit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (wrEn) begin
         resultReg  <= exRd;
         resultData <= aluOut;                    // also the forwarding source.
      end
   end

endmodule

//--- logic/decodeExecCore.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module decodeExecCore (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    instrValid,
   input  logic [`CORE_DATA_W-1:0] instr,
   output logic                    creditReturn,
   output logic                    resultValid,
   output corePkg::regIdxT         resultReg,
   output logic [`CORE_DATA_W-1:0] resultData,
   input  logic                    resultCredit
);
   import corePkg::*;

   // ------------------------------
   // decode side
   // ------------------------------
   logic                    decValid;
   aluOpE                   decAluOp;
   regIdxT                  decRd;
   regIdxT                  rs1Idx;
   regIdxT                  rs2Idx;
   logic                    decWrites;
   logic                    decUseImm;
   logic [`CORE_DATA_W-1:0] decImm;
   logic [`CORE_DATA_W-1:0] rdData1;
   logic [`CORE_DATA_W-1:0] rdData2;

   // ------------------------------
   // execute side
   // ------------------------------
   logic                    exValid;
   aluOpE                   exAluOp;
   regIdxT                  exRd;
   regIdxT                  exRs1;
   regIdxT                  exRs2;
   logic                    exWrites;
   logic                    exUseImm;
   logic [`CORE_DATA_W-1:0] exImm;
   logic [`CORE_DATA_W-1:0] exOpA;
   logic [`CORE_DATA_W-1:0] exOpB;
   logic                    exAdvance;
   logic                    wrEn;
   regIdxT                  wrIdx;
   logic [`CORE_DATA_W-1:0] wrData;

   instrDecoder   u_instrDecoder   (.*);
   regFile        u_regFile        (.*);
   decodeStageReg u_decodeStageReg (.*);
   executeUnit    u_executeUnit    (.*);

endmodule

//--- testbench/coreTb_chk.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module coreTb_chk (
   input logic CLK,
   input logic rst,
   input logic instrValid,
   input logic creditReturn,
   input logic resultValid,
   input logic resultCredit
);

   int inCredits;
   int outCredits;
   int failCount = 0;

   // ------------------------------
   // credit counts seen from outside
   // ------------------------------
   always_ff @(posedge CLK) begin
      if (rst) begin
         inCredits  <= `CORE_QUEUE_DEPTH;
         outCredits <= `CORE_OUT_CREDITS;
      end else begin
         inCredits  <= inCredits - int'(instrValid) + int'(creditReturn);
         outCredits <= outCredits - int'(resultValid) + int'(resultCredit);
      end
   end

   // ------------------------------
   // credit rules
   // ------------------------------
   sendHasCredit: assert property (@(posedge CLK) disable iff (rst)
      instrValid |-> inCredits > 0)
      else begin
         $error("instrValid asserted with no input credit left");
         failCount++;
      end

   resultHasCredit: assert property (@(posedge CLK) disable iff (rst)
      resultValid |-> outCredits > 0)
      else begin
         $error("resultValid asserted with no output credit left");
         failCount++;
      end

   quietAfterReset: assert property (@(posedge CLK) rst |=> !creditReturn)
      else begin
         $error("creditReturn high right after reset");
         failCount++;
      end

endmodule

bind decodeExecCore coreTb_chk u_coreTb_chk (.*);

//--- testbench/coreTb.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module coreTb;
   import corePkg::*;

   logic                    CLK;
   logic                    rst;
   logic                    instrValid;
   logic [`CORE_DATA_W-1:0] instr;
   logic                    creditReturn;
   logic                    resultValid;
   regIdxT                  resultReg;
   logic [`CORE_DATA_W-1:0] resultData;
   logic                    resultCredit;

   logic [`CORE_DATA_W-1:0] regModel [`CORE_NUM_REGS];
   regIdxT                  expReg [$];
   logic [`CORE_DATA_W-1:0] expData [$];
   int                      sentCount = 0;
   int                      returnedCount = 0;
   int                      resultCount = 0;
   int                      pendingCredits = 0;    // output credits owed to the core.
   int                      inCredits = `CORE_QUEUE_DEPTH;
   logic                    holdCredits = 1'b0;
   integer                  seed;

   decodeExecCore u_decodeExecCore (.*);

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "run stopped");
   endtask

   function automatic logic [15:0] rType(opcodeE op, regIdxT rd, regIdxT rs1, regIdxT rs2);
      return {op, rd, rs1, rs2, 3'b000};
   endfunction

   function automatic logic [15:0] iType(opcodeE op, regIdxT rd, regIdxT rs1, logic [5:0] imm);
      return {op, rd, rs1, imm};
   endfunction

   // ------------------------------
   // reference model
   // ------------------------------
   task automatic modelInstr(input logic [15:0] word);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] imm;
      logic [15:0] res;
      a   = regModel[word[8:6]];
      b   = regModel[word[5:3]];
      imm = {{10{word[5]}}, word[5:0]};
      case (opcodeE'(word[15:12]))
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_AND:  res = a & b;
         OP_OR:   res = a | b;
         OP_XOR:  res = a ^ b;
         OP_ADDI: res = a + imm;
         OP_LDI:  res = imm;
         default: return;                          // NOP gives no result.
      endcase
      regModel[word[11:9]] = res;
      expReg.push_back(word[11:9]);
      expData.push_back(res);
   endtask

   task automatic sendInstr(input logic [15:0] word);
      @(posedge CLK);
      #1;
      instrValid = 1'b0;
      while (inCredits == 0) begin
         @(posedge CLK);
         #1;
      end
      instr      = word;
      instrValid = 1'b1;
      inCredits--;
      sentCount++;
      modelInstr(word);
   endtask

   task automatic drainAll();
      @(posedge CLK);
      #1;
      instrValid = 1'b0;
      while (expReg.size() != 0 || pendingCredits != 0 || sentCount != returnedCount) begin
         @(posedge CLK);
         #1;
      end
      repeat (3) @(posedge CLK);
      #1;
   endtask

   // the consumer hands back one output credit per cycle.
   initial begin
      forever begin
         @(posedge CLK);
         #1;
         if (!holdCredits && pendingCredits > 0) begin
            resultCredit = 1'b1;
            pendingCredits--;
         end else begin
            resultCredit = 1'b0;
         end
      end
   end

   always @(negedge CLK) begin
      if (!rst) begin
         if (creditReturn) begin
            returnedCount++;
            inCredits++;
         end
         assert (returnedCount <= sentCount)
            else abortRun("creditReturn pulsed with no instruction outstanding");
         if (resultValid) begin
            assert (expReg.size() != 0) else abortRun("a result arrived with none expected");
            assert (resultReg == expReg[0]) else abortRun($sformatf(
               "mismatch at %0t: resultReg %0d, expected %0d", $time, resultReg, expReg[0]));
            assert (resultData == expData[0]) else abortRun($sformatf(
               "mismatch at %0t: resultData %h, expected %h", $time, resultData, expData[0]));
            void'(expReg.pop_front());
            void'(expData.pop_front());
            resultCount++;
            pendingCredits++;
         end
      end
   end

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic checkAfterReset();
      repeat (10) begin
         @(negedge CLK);
         assert (!resultValid && !creditReturn)
            else abortRun("resultValid or creditReturn went high with no traffic");
      end
      sendInstr(rType(OP_ADD, 3, 0, 0));           // r0 reads back zero.
      drainAll();
   endtask

   task automatic checkAluOps();
      sendInstr(iType(OP_LDI, 1, 0, 6'h0d));
      sendInstr(iType(OP_LDI, 2, 0, 6'h39));       // minus seven.
      drainAll();
      sendInstr(rType(OP_ADD, 3, 1, 2));
      sendInstr(rType(OP_SUB, 4, 1, 2));
      sendInstr(rType(OP_AND, 5, 1, 2));
      sendInstr(rType(OP_OR, 6, 1, 2));
      sendInstr(rType(OP_XOR, 7, 1, 2));
      sendInstr(iType(OP_ADDI, 3, 2, 6'h2a));
      drainAll();
   endtask

   task automatic checkForwarding();
      sendInstr(iType(OP_LDI, 1, 0, 6'h05));
      sendInstr(rType(OP_ADD, 2, 1, 1));
      sendInstr(rType(OP_ADD, 3, 2, 1));
      sendInstr(rType(OP_SUB, 4, 3, 2));
      sendInstr(rType(OP_XOR, 5, 4, 3));
      sendInstr(iType(OP_ADDI, 6, 5, 6'h3d));
      sendInstr(rType(OP_AND, 7, 6, 5));
      sendInstr(rType(OP_OR, 1, 7, 6));
      drainAll();
   endtask

   task automatic checkInputCredits();
      logic [31:0] rnd;
      for (int i = 0; i < 18; i++) begin
         rnd = $random(seed);
         if (i % 6 == 5) begin
            rnd[14:12] = 3'd0;                     // every sixth one is a NOP.
         end
         sendInstr({1'b0, rnd[14:0]});
      end
      drainAll();
   endtask

   task automatic checkBackPressure();
      int startResults;
      startResults = resultCount;
      holdCredits  = 1'b1;
      fork
         begin
            for (int i = 0; i < 8; i++) begin
               sendInstr(iType(OP_ADDI, regIdxT'(i), regIdxT'(i + 7), 6'(i * 5)));
            end
         end
         begin
            repeat (40) @(posedge CLK);
            #1;
            assert (resultCount - startResults == `CORE_OUT_CREDITS) else abortRun($sformatf(
               "mismatch at %0t: %0d results while credits were held", $time,
               resultCount - startResults));
            holdCredits = 1'b0;
         end
      join
      drainAll();
   endtask

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles <= 200 * sentCount + 500) begin
         @(posedge CLK);
         cycles++;
      end
      abortRun("timeout: the DUT stopped returning results or credits");
   end

   initial begin
      seed         = 32'h8bab0f17;
      rst          = 1'b1;
      instrValid   = 1'b0;
      instr        = '0;
      resultCredit = 1'b0;
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
         regModel[i] = '0;
      end
      repeat (8) @(posedge CLK);
      #1;
      rst = 1'b0;
      checkAfterReset();
      checkAluOps();
      checkForwarding();
      checkInputCredits();
      checkBackPressure();
      if (u_decodeExecCore.u_coreTb_chk.failCount == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         abortRun("a credit assertion in the checker failed");
      end
   end

endmodule

//--- files.f
+incdir+logic
logic/corePkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/decodeStageReg.sv
logic/executeUnit.sv
logic/decodeExecCore.sv
testbench/coreTb_chk.sv
testbench/coreTb.sv

//--- Bender.yml
package:
  name: decode_exec_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/corePkg.sv
      - logic/instrDecoder.sv
      - logic/regFile.sv
      - logic/decodeStageReg.sv
      - logic/executeUnit.sv
      - logic/decodeExecCore.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/coreTb_chk.sv
      - testbench/coreTb.sv
